//--- Makefile
# Verilator flow for the issue core testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= issue_core_tb
FILELIST   ?= issue_core.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_TEXT  ?= Simulation finished: FAIL
PASS_TEXT  ?= Simulation finished: PASS
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Testbench reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- issue_core.f
+incdir+include
logic/issue_pkg.sv
logic/rs_bank.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/cdb_arbiter.sv
logic/issue_core.sv
tb/issue_core_tb.sv

//--- logic/alu_unit.sv
////////////////////////////////////////////////////////////
// ALU execution unit
// Single-stage adder with a result register that holds
// its bus request until the arbiter grants it
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module alu_unit
    import issue_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        flush,

    // From the ALU bank
    input  logic        issue_valid,
    input  rs_entry_t   issue_entry,
    output logic        issue_ready,

    // To the bus arbiter
    output fu_request_t request,
    input  logic        grant
);

    fu_request_t result_q;

    // Free slot now, or the held result leaves this cycle
    assign issue_ready = !result_q.valid || grant;
    assign request     = result_q;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            result_q.valid <= 1'b0;
        end else if (issue_valid && issue_ready) begin
            result_q.valid    <= 1'b1;
            result_q.dest_tag <= issue_entry.dest_tag;
            // Zero-extended sum
            result_q.result   <= result_width'(issue_entry.operand_a)
                               + result_width'(issue_entry.operand_b);
        end else if (grant) begin
            result_q.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/cdb_arbiter.sv
////////////////////////////////////////////////////////////
// Common data bus arbiter
// Grants one unit result per cycle with the multiplier
// first, broadcasts its tag at once and registers it
// onto the bus for the next cycle
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter
    import issue_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        flush,

    // Unit requests
    input  fu_request_t alu_request,
    input  fu_request_t mult_request,

    // Grants back to the units
    output logic        alu_grant,
    output logic        mult_grant,

    // Wakeup tag in the grant cycle
    output early_tag_t  early_tag,

    // Registered bus
    output cdb_packet_t cdb
);

    fu_request_t winner;

    // Multiplier wins, a stalled multiplier blocks three results
    assign mult_grant = mult_request.valid;
    assign alu_grant  = alu_request.valid && !mult_request.valid;

    assign winner = mult_request.valid ? mult_request : alu_request;

    assign early_tag.valid = winner.valid;
    assign early_tag.tag   = winner.dest_tag;

    ////////////////////////////////////////////////////////////
    // Bus register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid  <= winner.valid;
            cdb.tag    <= winner.dest_tag;
            cdb.result <= winner.result;
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_core.sv
////////////////////////////////////////////////////////////
// Out-of-order issue and completion core
// Steers dispatched instructions into the ALU or multiply
// reservation station and joins banks, units and the
// common data bus arbiter
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module issue_core
    import issue_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             flush,

    // Dispatch port
    input  logic             dispatch_valid,
    input  dispatch_packet_t dispatch_packet,
    output logic             dispatch_ready,

    // Completed results
    output cdb_packet_t      cdb
);

    ////////////////////////////////////////////////////////////
    // Wires
    ////////////////////////////////////////////////////////////

    // Dispatch packet without its class
    rs_entry_t   dispatch_entry;
    logic        is_mult;

    // Bank handshakes
    logic        alu_alloc_ready;
    logic        mult_alloc_ready;
    logic        alu_issue_valid;
    logic        mult_issue_valid;
    rs_entry_t   alu_issue_entry;
    rs_entry_t   mult_issue_entry;
    logic        alu_issue_ready;
    logic        mult_issue_ready;

    // Completion side
    fu_request_t alu_request;
    fu_request_t mult_request;
    logic        alu_grant;
    logic        mult_grant;
    early_tag_t  early_tag;

    assign dispatch_entry = '{
        busy:       1'b1,
        dest_tag:   dispatch_packet.dest_tag,
        src1_tag:   dispatch_packet.src1_tag,
        src1_ready: dispatch_packet.src1_ready,
        src2_tag:   dispatch_packet.src2_tag,
        src2_ready: dispatch_packet.src2_ready,
        operand_a:  dispatch_packet.operand_a,
        operand_b:  dispatch_packet.operand_b
    };

    // Class steering, ready follows the target bank
    assign is_mult        = (dispatch_packet.fu_class == fu_mult);
    assign dispatch_ready = !flush && (is_mult ? mult_alloc_ready : alu_alloc_ready);

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////

    rs_bank #(.depth(rs_alu_depth)) i_rs_alu (
        .clock(clock), .reset(reset), .flush(flush),
        .alloc_valid(dispatch_valid && !is_mult),
        .alloc_entry(dispatch_entry), .alloc_ready(alu_alloc_ready),
        .early_tag(early_tag),
        .issue_valid(alu_issue_valid), .issue_entry(alu_issue_entry),
        .issue_ready(alu_issue_ready)
    );

    rs_bank #(.depth(rs_mult_depth)) i_rs_mult (
        .clock(clock), .reset(reset), .flush(flush),
        .alloc_valid(dispatch_valid && is_mult),
        .alloc_entry(dispatch_entry), .alloc_ready(mult_alloc_ready),
        .early_tag(early_tag),
        .issue_valid(mult_issue_valid), .issue_entry(mult_issue_entry),
        .issue_ready(mult_issue_ready)
    );

    alu_unit i_alu (
        .clock(clock), .reset(reset), .flush(flush),
        .issue_valid(alu_issue_valid), .issue_entry(alu_issue_entry),
        .issue_ready(alu_issue_ready),
        .request(alu_request), .grant(alu_grant)
    );

    mult_unit i_mult (
        .clock(clock), .reset(reset), .flush(flush),
        .issue_valid(mult_issue_valid), .issue_entry(mult_issue_entry),
        .issue_ready(mult_issue_ready),
        .request(mult_request), .grant(mult_grant)
    );

    cdb_arbiter i_cdb (
        .clock(clock), .reset(reset), .flush(flush),
        .alu_request(alu_request), .mult_request(mult_request),
        .alu_grant(alu_grant), .mult_grant(mult_grant),
        .early_tag(early_tag), .cdb(cdb)
    );

endmodule

`default_nettype wire

//--- logic/issue_pkg.sv
////////////////////////////////////////////////////////////
// Issue core shared definitions
// Widths, tags, unit classes and the packed structs that
// travel between dispatch, the reservation stations, the
// execution units and the common data bus
////////////////////////////////////////////////////////////

`default_nettype none

package issue_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    // Physical register tag width
    localparam int tag_width     = 6;
    // Immediate operand and bus result widths
    localparam int operand_width = 16;
    localparam int result_width  = 32;

    // Reservation station depths per class
    localparam int rs_alu_depth  = 4;
    localparam int rs_mult_depth = 2;

    // Multiplier pipeline length, issue to bus request
    localparam int mult_stages   = 3;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [tag_width-1:0] phys_tag_t;

    // Functional unit class picked at dispatch
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_class_t;

    // Instruction as it arrives from dispatch
    typedef struct packed {
        phys_tag_t                dest_tag;
        phys_tag_t                src1_tag;
        logic                     src1_ready;
        phys_tag_t                src2_tag;
        logic                     src2_ready;
        logic [operand_width-1:0] operand_a;
        logic [operand_width-1:0] operand_b;
        fu_class_t                fu_class;
    } dispatch_packet_t;

    // One reservation station slot, class implied by the bank
    typedef struct packed {
        logic                     busy;
        phys_tag_t                dest_tag;
        phys_tag_t                src1_tag;
        logic                     src1_ready;
        phys_tag_t                src2_tag;
        logic                     src2_ready;
        logic [operand_width-1:0] operand_a;
        logic [operand_width-1:0] operand_b;
    } rs_entry_t;

    // Finished result waiting for a bus grant
    typedef struct packed {
        logic                    valid;
        phys_tag_t               dest_tag;
        logic [result_width-1:0] result;
    } fu_request_t;

    // Registered common data bus
    typedef struct packed {
        logic                    valid;
        phys_tag_t               tag;
        logic [result_width-1:0] result;
    } cdb_packet_t;

    // Tag granted this cycle, one cycle ahead of the bus
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } early_tag_t;

endpackage

`default_nettype wire

//--- logic/mult_unit.sv
////////////////////////////////////////////////////////////
// Multiply execution unit
// Pipelined multiplier of mult_stages stages; the whole
// pipeline freezes while its last stage waits for a grant
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mult_unit
    import issue_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        flush,

    // From the multiply bank
    input  logic        issue_valid,
    input  rs_entry_t   issue_entry,
    output logic        issue_ready,

    // To the bus arbiter
    output fu_request_t request,
    input  logic        grant
);

    // First stage keeps the raw operands
    typedef struct packed {
        logic                     valid;
        phys_tag_t                dest_tag;
        logic [operand_width-1:0] operand_a;
        logic [operand_width-1:0] operand_b;
    } operand_stage_t;

    operand_stage_t                    operand_q;
    // Later stages carry the finished product
    fu_request_t [mult_stages-1:1]     product_q;
    logic                              advance;

    // Move only if the last stage is empty or leaving
    assign advance     = !product_q[mult_stages-1].valid || grant;
    assign issue_ready = advance;
    assign request     = product_q[mult_stages-1];

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            operand_q.valid <= 1'b0;
            for (int s = 1; s < mult_stages; s++) begin
                product_q[s].valid <= 1'b0;
            end
        end else if (advance) begin
            // Stage 0 capture
            operand_q.valid     <= issue_valid;
            operand_q.dest_tag  <= issue_entry.dest_tag;
            operand_q.operand_a <= issue_entry.operand_a;
            operand_q.operand_b <= issue_entry.operand_b;
            // Stage 1 multiply
            product_q[1].valid    <= operand_q.valid;
            product_q[1].dest_tag <= operand_q.dest_tag;
            product_q[1].result   <= result_width'(operand_q.operand_a)
                                   * result_width'(operand_q.operand_b);
            // Remaining stages shift
            for (int s = 2; s < mult_stages; s++) begin
                product_q[s] <= product_q[s-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rs_bank.sv
////////////////////////////////////////////////////////////
// Reservation station bank
// Holds waiting instructions of one class, wakes their
// sources on the early tag broadcast and issues the
// lowest-index entry with both sources ready
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rs_bank
    import issue_pkg::*;
#(
    parameter int depth = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,

    // From dispatch
    input  logic       alloc_valid,
    input  rs_entry_t  alloc_entry,
    output logic       alloc_ready,

    // Wakeup broadcast from the bus arbiter
    input  early_tag_t early_tag,

    // To the execution unit
    output logic       issue_valid,
    output rs_entry_t  issue_entry,
    input  logic       issue_ready
);

    localparam int idx_width = (depth > 1) ? $clog2(depth) : 1;

    rs_entry_t [depth-1:0] entries;

    logic                 have_free;
    logic [idx_width-1:0] alloc_idx;
    logic                 have_ready;
    logic [idx_width-1:0] issue_idx;
    rs_entry_t            alloc_woken;

    // Set the ready bit of any pending source matching the broadcast
    function automatic rs_entry_t wake(input rs_entry_t entry, input early_tag_t bcast);
        rs_entry_t woken;
        woken = entry;
        if (bcast.valid && entry.src1_tag == bcast.tag) begin
            woken.src1_ready = 1'b1;
        end
        if (bcast.valid && entry.src2_tag == bcast.tag) begin
            woken.src2_ready = 1'b1;
        end
        return woken;
    endfunction

    ////////////////////////////////////////////////////////////
    // Slot selection
    ////////////////////////////////////////////////////////////

    // Walk downward so the lowest index wins both searches
    always_comb begin
        have_free  = 1'b0;
        alloc_idx  = '0;
        have_ready = 1'b0;
        issue_idx  = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!entries[i].busy) begin
                have_free = 1'b1;
                alloc_idx = idx_width'(i);
            end
            if (entries[i].busy && entries[i].src1_ready && entries[i].src2_ready) begin
                have_ready = 1'b1;
                issue_idx  = idx_width'(i);
            end
        end
    end

    assign alloc_ready = have_free;
    assign issue_valid = have_ready;
    assign issue_entry = entries[issue_idx];

    // Incoming packet sees the same broadcast as stored entries
    always_comb begin
        alloc_woken      = wake(alloc_entry, early_tag);
        alloc_woken.busy = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            for (int i = 0; i < depth; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= wake(entries[i], early_tag);
            end
            // Issue and allocate never touch the same slot
            if (issue_valid && issue_ready) begin
                entries[issue_idx].busy <= 1'b0;
            end
            if (alloc_valid && alloc_ready) begin
                entries[alloc_idx] <= alloc_woken;
            end
        end
    end

endmodule

`default_nettype wire

//--- include/issue_tests.svh
////////////////////////////////////////////////////////////
// Issue core test table
// One row per step of idle check, dispatch, full-bank probe,
// flush pulse or drain. Rows of one test share a test id
////////////////////////////////////////////////////////////

`ifndef ISSUE_TESTS_SVH
`define ISSUE_TESTS_SVH

// Step kinds
typedef enum logic [2:0] {
    op_idle,
    op_send,
    op_full,
    op_flush,
    op_drain
} test_op_t;

// Ready bit 0 means the source waits on that tag
typedef struct packed {
    logic [3:0] test_id;
    test_op_t   op;
    fu_class_t  fu_class;
    phys_tag_t  dest;
    phys_tag_t  src1;
    logic       src1_ready;
    phys_tag_t  src2;
    logic       src2_ready;
    logic       expect_out;
} test_row_t;

localparam int table_len = 42;

localparam test_row_t test_table [table_len] = '{
    // test, step, class, dest, src1, src1 ready, src2, src2 ready, on bus
    // Reset state
    '{4'd1, op_idle,  fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    '{4'd1, op_drain, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    // Independent work
    '{4'd2, op_send,  fu_alu,  6'd1,  6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd2, op_send,  fu_mult, 6'd2,  6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd2, op_send,  fu_alu,  6'd3,  6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd2, op_send,  fu_mult, 6'd4,  6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd2, op_send,  fu_alu,  6'd5,  6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd2, op_send,  fu_mult, 6'd6,  6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd2, op_drain, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    // Dependency chain across both classes
    '{4'd3, op_send,  fu_mult, 6'd10, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd3, op_send,  fu_alu,  6'd11, 6'd10, 1'b0, 6'd0,  1'b1, 1'b1},
    '{4'd3, op_send,  fu_mult, 6'd12, 6'd11, 1'b0, 6'd10, 1'b0, 1'b1},
    '{4'd3, op_send,  fu_alu,  6'd13, 6'd12, 1'b0, 6'd11, 1'b0, 1'b1},
    '{4'd3, op_send,  fu_alu,  6'd14, 6'd0,  1'b1, 6'd13, 1'b0, 1'b1},
    '{4'd3, op_drain, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    // Full ALU bank waiting on tag 40
    '{4'd4, op_send,  fu_alu,  6'd20, 6'd40, 1'b0, 6'd0,  1'b1, 1'b1},
    '{4'd4, op_send,  fu_alu,  6'd21, 6'd40, 1'b0, 6'd0,  1'b1, 1'b1},
    '{4'd4, op_send,  fu_alu,  6'd22, 6'd0,  1'b1, 6'd40, 1'b0, 1'b1},
    '{4'd4, op_send,  fu_alu,  6'd23, 6'd40, 1'b0, 6'd40, 1'b0, 1'b1},
    '{4'd4, op_full,  fu_alu,  6'd24, 6'd40, 1'b0, 6'd0,  1'b1, 1'b0},
    '{4'd4, op_send,  fu_mult, 6'd40, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd4, op_send,  fu_alu,  6'd24, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd4, op_drain, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    // Mixed burst on the bus
    '{4'd5, op_send,  fu_mult, 6'd30, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_alu,  6'd31, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_mult, 6'd32, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_alu,  6'd33, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_mult, 6'd34, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_alu,  6'd35, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_alu,  6'd36, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_alu,  6'd37, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_mult, 6'd38, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_send,  fu_alu,  6'd39, 6'd38, 1'b0, 6'd0,  1'b1, 1'b1},
    '{4'd5, op_drain, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    // Flush of work stuck on tag 63, then fresh work that produces tag 63
    // Any entry left behind by the flush would wake and reach the bus
    '{4'd6, op_send,  fu_alu,  6'd50, 6'd63, 1'b0, 6'd0,  1'b1, 1'b0},
    '{4'd6, op_send,  fu_mult, 6'd51, 6'd0,  1'b1, 6'd63, 1'b0, 1'b0},
    '{4'd6, op_send,  fu_alu,  6'd52, 6'd51, 1'b0, 6'd0,  1'b1, 1'b0},
    '{4'd6, op_flush, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0},
    '{4'd6, op_send,  fu_alu,  6'd63, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd6, op_send,  fu_mult, 6'd54, 6'd0,  1'b1, 6'd0,  1'b1, 1'b1},
    '{4'd6, op_send,  fu_alu,  6'd55, 6'd54, 1'b0, 6'd0,  1'b1, 1'b1},
    '{4'd6, op_drain, fu_alu,  6'd0,  6'd0,  1'b1, 6'd0,  1'b1, 1'b0}
};

`endif

//--- tb/issue_core_tb.sv
////////////////////////////////////////////////////////////
// Issue core testbench
// Applies the test table to the core, predicts each bus
// result from its operands, checks order, count and
// back-pressure, then prints a summary
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module issue_core_tb
    import issue_pkg::*;
();

    localparam int tag_count  = 1 << tag_width;
    // Idle cycles after a drain to catch late or duplicate results
    localparam int drain_tail = 6;

    logic             clock;
    logic             reset;
    logic             flush;
    logic             dispatch_valid;
    dispatch_packet_t dispatch_packet;
    logic             dispatch_ready;
    cdb_packet_t      cdb;

    `include "issue_tests.svh"

    localparam int timeout_cycles = table_len * 20;

    // Scoreboard, indexed by destination tag
    logic                    pending         [tag_count];
    logic                    seen            [tag_count];
    logic [result_width-1:0] expected_result [tag_count];
    logic                    waits_src1      [tag_count];
    logic                    waits_src2      [tag_count];
    phys_tag_t               src1_of         [tag_count];
    phys_tag_t               src2_of         [tag_count];

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;

    issue_core i_dut (
        .clock(clock), .reset(reset), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch_packet(dispatch_packet),
        .dispatch_ready(dispatch_ready), .cdb(cdb)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Checks and scoreboard helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [result_width-1:0] actual,
                               input logic [result_width-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    // A waiting source must have been on the bus in an earlier cycle
    task automatic check_order(input phys_tag_t tag, input logic waits, input phys_tag_t src);
        if (waits && !seen[src]) begin
            $display("Failure at %0t ns: tag %0d reached the bus before its source tag %0d",
                     $time, tag, src);
            error_count++;
        end
    endtask

    task automatic clear_scoreboard();
        int t;
        for (t = 0; t < tag_count; t++) begin
            pending[t]    = 1'b0;
            seen[t]       = 1'b0;
            waits_src1[t] = 1'b0;
            waits_src2[t] = 1'b0;
        end
    endtask

    function automatic int outstanding();
        int count;
        int t;
        count = 0;
        for (t = 0; t < tag_count; t++) begin
            if (pending[t]) begin
                count++;
            end
        end
        return count;
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset state";
            4'd2:    return "independent instructions";
            4'd3:    return "dependency chains";
            4'd4:    return "full bank";
            4'd5:    return "arbitration under load";
            4'd6:    return "flush";
            default: return "unnamed";
        endcase
    endfunction

    // Table row to packet, operands from the seeded generator
    task automatic make_packet(input test_row_t row, output dispatch_packet_t pkt);
        logic [31:0] rand_word;
        rand_word      = $random(seed);
        pkt.operand_a  = rand_word[15:0];
        rand_word      = $random(seed);
        pkt.operand_b  = rand_word[15:0];
        pkt.dest_tag   = row.dest;
        pkt.src1_tag   = row.src1;
        pkt.src1_ready = row.src1_ready;
        pkt.src2_tag   = row.src2;
        pkt.src2_ready = row.src2_ready;
        pkt.fu_class   = row.fu_class;
    endtask

    ////////////////////////////////////////////////////////////
    // Steps, each entered and left on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic idle_check(input int cycles);
        int c;
        dispatch_valid = 1'b0;
        for (c = 0; c < cycles; c++) begin
            #1;
            check_value("cdb.valid", result_width'(cdb.valid), '0);
            check_value("dispatch_ready", result_width'(dispatch_ready), result_width'(1));
            @(negedge clock);
        end
    endtask

    task automatic send_row(input test_row_t row);
        dispatch_packet_t        pkt;
        logic [result_width-1:0] a_ext;
        logic [result_width-1:0] b_ext;
        make_packet(row, pkt);
        a_ext = {{(result_width-operand_width){1'b0}}, pkt.operand_a};
        b_ext = {{(result_width-operand_width){1'b0}}, pkt.operand_b};
        // Expect sum for the ALU and product for the multiplier
        if (row.expect_out) begin
            pending[row.dest]         = 1'b1;
            expected_result[row.dest] = (row.fu_class == fu_mult) ? a_ext * b_ext
                                                                   : a_ext + b_ext;
            waits_src1[row.dest]      = !row.src1_ready;
            waits_src2[row.dest]      = !row.src2_ready;
            src1_of[row.dest]         = row.src1;
            src2_of[row.dest]         = row.src2;
        end
        dispatch_packet = pkt;
        dispatch_valid  = 1'b1;
        #1;
        while (!dispatch_ready) begin
            @(negedge clock);
            #1;
        end
        // Transfer on the rising edge in between
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    // Packet shown without valid, the target bank must be full
    task automatic full_check(input test_row_t row);
        dispatch_packet_t pkt;
        make_packet(row, pkt);
        dispatch_packet = pkt;
        dispatch_valid  = 1'b0;
        repeat (2) begin
            #1;
            check_value("dispatch_ready", result_width'(dispatch_ready), '0);
            @(negedge clock);
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        #1;
        check_value("dispatch_ready", result_width'(dispatch_ready), '0);
        @(negedge clock);
        flush = 1'b0;
    endtask

    task automatic drain_and_report(input logic [3:0] id, input int errors_before);
        #1;
        while (outstanding() != 0) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        repeat (drain_tail) @(negedge clock);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %0d, %s: passed", id, test_name(id));
        end else begin
            tests_failed++;
            $display("Test %0d, %s: failed with %0d errors",
                     id, test_name(id), error_count - errors_before);
        end
        clear_scoreboard();
    endtask

    ////////////////////////////////////////////////////////////
    // Bus monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && cdb.valid) begin
            if (!pending[cdb.tag]) begin
                $display("Failure at %0t ns: bus carried tag %0d, which was not outstanding",
                         $time, cdb.tag);
                error_count++;
            end else begin
                check_value($sformatf("cdb.result of tag %0d", cdb.tag),
                            cdb.result, expected_result[cdb.tag]);
                check_order(cdb.tag, waits_src1[cdb.tag], src1_of[cdb.tag]);
                check_order(cdb.tag, waits_src2[cdb.tag], src2_of[cdb.tag]);
                pending[cdb.tag] = 1'b0;
            end
            seen[cdb.tag] = 1'b1;
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Failure: run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Table sequencer
    ////////////////////////////////////////////////////////////

    initial begin
        test_row_t  row;
        logic [3:0] current_test;
        int         errors_before;
        int         r;

        seed            = 96441;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        reset           = 1'b1;
        flush           = 1'b0;
        dispatch_valid  = 1'b0;
        dispatch_packet = '0;
        current_test    = '0;
        errors_before   = 0;
        clear_scoreboard();

        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (r = 0; r < table_len; r++) begin
            row = test_table[r];
            if (row.test_id != current_test) begin
                current_test  = row.test_id;
                errors_before = error_count;
            end
            case (row.op)
                op_idle:  idle_check(4);
                op_send:  send_row(row);
                op_full:  full_check(row);
                op_flush: pulse_flush();
                // op_drain closes the test
                default:  drain_and_report(row.test_id, errors_before);
            endcase
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
